//--- bench/lsu_tb.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int MEM_BYTES      = `LSU_MEM_WORDS * 4;
    localparam int BYTE_AW        = $clog2(MEM_BYTES);
    // words written at start, every later op stays inside them
    localparam int FILL_WORDS     = 32;
    localparam int DIRECTED_OPS   = 35;
    localparam int RANDOM_OPS     = 300;
    localparam int TOTAL_OPS      = FILL_WORDS + DIRECTED_OPS + RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * (`LSU_MEM_LATENCY + 8) + 200;

    logic        clk_i;
    logic        rst_n_i;
    logic        op_valid_i;
    logic        is_store_i;
    logic [2:0]  funct3_i;
    logic [31:0] base_i;
    logic [31:0] offset_i;
    logic [31:0] store_data_i;
    logic        op_ready_o;
    logic        result_valid_o;
    logic [31:0] result_data_o;
    logic        result_ready_i;

    logic [7:0]  model_mem [MEM_BYTES];
    logic [31:0] stim_seed;
    logic [31:0] stall_seed;
    logic [31:0] exp_load;
    logic [31:0] last_result;
    logic        ld_accept;
    logic        st_accept;
    int          loads_issued;
    int          results_seen;
    int          errors;

    lsu_top dut0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .op_valid_i     (op_valid_i),
        .is_store_i     (is_store_i),
        .funct3_i       (funct3_i),
        .base_i         (base_i),
        .offset_i       (offset_i),
        .store_data_i   (store_data_i),
        .op_ready_o     (op_ready_o),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o),
        .result_ready_i (result_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    function automatic logic [7:0] model_byte(input logic [31:0] addr);
        return model_mem[addr[BYTE_AW-1:0]];
    endfunction

    // little endian lanes, funct3[2] selects zero extension
    function automatic logic [31:0] expected_load(input logic [2:0] f3,
                                                  input logic [31:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = model_byte(addr);
        h = {model_byte(addr + 32'd1), b};
        case (f3)
            3'd0:    return {{24{b[7]}}, b};
            3'd4:    return {24'b0, b};
            3'd1:    return {{16{h[15]}}, h};
            3'd5:    return {16'b0, h};
            default: return {model_byte(addr + 32'd3), model_byte(addr + 32'd2), h};
        endcase
    endfunction

    task automatic update_model(input logic [2:0] f3, input logic [31:0] addr,
                                input logic [31:0] data);
        int                 n;
        logic [BYTE_AW-1:0] idx;
        n = (f3[1:0] == 2'd0) ? 1 : ((f3[1:0] == 2'd1) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            idx = BYTE_AW'(addr + 32'(i));
            model_mem[idx] = data[8*i +: 8];
        end
    endtask

    task automatic value_error(input string sig, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        errors++;
        $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp_v, got_v);
    endtask

    task automatic protocol_error(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    // drives one op from a falling edge and holds it until it is taken
    task automatic issue_op(input logic st, input logic [2:0] f3,
                            input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] r;
        logic [31:0] off;
        r   = next_stim();
        // offsets from -32 to 31
        off = 32'(r[13:8]) - 32'd32;
        is_store_i   = st;
        funct3_i     = f3;
        offset_i     = off;
        base_i       = addr - off;
        store_data_i = data;
        op_valid_i   = 1'b1;
        while (op_ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
        // transfer happens on the coming rising edge
        if (st) begin
            update_model(f3, addr, data);
        end else begin
            exp_load = expected_load(f3, addr);
            loads_issued++;
        end
        @(negedge clk_i);
        op_valid_i = 1'b0;
    endtask

    // every signed and unsigned byte and halfword view of one word
    task automatic sweep_lanes(input logic [31:0] word_addr);
        for (int l = 0; l < 4; l++) begin
            issue_op(1'b0, 3'd0, word_addr + 32'(l), 32'd0);
            issue_op(1'b0, 3'd4, word_addr + 32'(l), 32'd0);
        end
        for (int l = 0; l < 4; l += 2) begin
            issue_op(1'b0, 3'd1, word_addr + 32'(l), 32'd0);
            issue_op(1'b0, 3'd5, word_addr + 32'(l), 32'd0);
        end
    endtask

    // ------------------------------------------------------------------------
    // result consumer with random stalls
    // ------------------------------------------------------------------------

    initial begin : result_sink
        int   stall;
        logic valid_seen;
        logic hs_next;
        stall          = 0;
        valid_seen     = 1'b0;
        hs_next        = 1'b0;
        result_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (hs_next) begin
                results_seen++;
            end
            // new result, draw 0 to 3 stall cycles
            if ((result_valid_o === 1'b1) && !valid_seen) begin
                stall_seed = lcg_next(stall_seed);
                stall      = int'(stall_seed[17:16]);
            end
            valid_seen     = (result_valid_o === 1'b1);
            result_ready_i = valid_seen && (stall == 0);
            if (valid_seen && (stall > 0)) begin
                stall--;
            end
            hs_next = valid_seen && result_ready_i;
        end
    end

    // ------------------------------------------------------------------------
    // main stimulus
    // ------------------------------------------------------------------------

    initial begin : stimulus
        logic        st;
        logic [2:0]  f3;
        logic [2:0]  sel;
        logic [1:0]  lane;
        logic [31:0] r;
        logic [31:0] addr;
        stim_seed    = 32'd68;
        stall_seed   = lcg_next(32'd68);
        loads_issued = 0;
        results_seen = 0;
        errors       = 0;
        exp_load     = 32'd0;
        rst_n_i      = 1'b0;
        op_valid_i   = 1'b0;
        is_store_i   = 1'b0;
        funct3_i     = 3'd0;
        base_i       = 32'd0;
        offset_i     = 32'd0;
        store_data_i = 32'd0;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        for (int w = 0; w < FILL_WORDS; w++) begin
            issue_op(1'b1, 3'd2, 32'(w * 4), next_stim());
        end

        // word store then word load
        issue_op(1'b1, 3'd2, 32'h40, 32'hdead_beef);
        issue_op(1'b0, 3'd2, 32'h40, 32'd0);

        // narrow stores touch only their lane
        for (int l = 0; l < 4; l++) begin
            issue_op(1'b1, 3'd0, 32'h44 + 32'(l), 32'h5a00 | 32'(l * 17));
        end
        issue_op(1'b0, 3'd2, 32'h44, 32'd0);
        issue_op(1'b1, 3'd1, 32'h48, 32'h1234_8765);
        issue_op(1'b1, 3'd1, 32'h4a, 32'h9999_7abc);
        issue_op(1'b0, 3'd2, 32'h48, 32'd0);

        // mixed sign bits in every byte and halfword
        issue_op(1'b1, 3'd2, 32'h4c, 32'hf07f_8001);
        sweep_lanes(32'h4c);
        sweep_lanes(32'h50);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = next_stim();
            st   = r[20];
            sel  = 3'(r[26:24] % (st ? 3'd3 : 3'd5));
            f3   = (sel < 3'd3) ? sel : sel + 3'd1;
            lane = r[29:28];
            addr = 32'(((r >> 8) % FILL_WORDS) * 4);
            if (f3[1:0] == 2'd0) begin
                addr = addr + 32'(lane);
            end else if (f3[1:0] == 2'd1) begin
                addr = addr + {30'd0, lane[1], 1'b0};
            end
            issue_op(st, f3, addr, next_stim());
        end

        while ((results_seen != loads_issued) || (op_ready_o !== 1'b1)) begin
            @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);

        $display("errors: %0d  loads: %0d  results: %0d", errors, loads_issued, results_seen);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d  loads: %0d  results: %0d", errors, loads_issued, results_seen);
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    assign ld_accept = op_valid_i & op_ready_o & ~is_store_i;
    assign st_accept = op_valid_i & op_ready_o & is_store_i;

    // result seen during the previous cycle
    always @(posedge clk_i) begin
        last_result <= result_data_o;
    end

    a_reset_state: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (op_ready_o && !result_valid_o))
        else protocol_error("op_ready_o low or result_valid_o high after reset");

    a_no_early_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (loads_issued == 0) |-> !result_valid_o)
        else protocol_error("result_valid_o high before any load");

    // rising edge of valid exactly latency + 2 cycles after the load
    a_load_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(result_valid_o) == $past(ld_accept, `LSU_MEM_LATENCY + 2))
        else protocol_error("result_valid_o rose at the wrong cycle");

    a_load_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (result_valid_o && result_ready_i) |-> (result_data_o == exp_load))
        else value_error("result_data_o", $sampled(exp_load), $sampled(result_data_o));

    a_one_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (result_valid_o && result_ready_i) |-> (results_seen + 1 == loads_issued))
        else protocol_error("result handed over without a matching load");

    a_serial_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (op_valid_i && op_ready_o) |->
            (results_seen + (is_store_i ? 0 : 1) == loads_issued))
        else protocol_error("op accepted while a load result was still pending");

    a_hold_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (result_valid_o && !result_ready_i) |=> result_valid_o)
        else protocol_error("result_valid_o dropped before the handshake");

    a_hold_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (result_valid_o && !result_ready_i) |=> (result_data_o == last_result))
        else value_error("result_data_o", $sampled(last_result), $sampled(result_data_o));

    a_busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_o |-> !op_ready_o)
        else protocol_error("op_ready_o high while a result waits");

    a_ready_after_hs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (result_valid_o && result_ready_i) |=> op_ready_o)
        else protocol_error("op_ready_o not back one cycle after the result handshake");

    a_store_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($past(st_accept) || $past(st_accept, 2)) |-> !op_ready_o)
        else protocol_error("op_ready_o high while a store was in progress");

    a_store_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(st_accept, 3) |-> op_ready_o)
        else protocol_error("op_ready_o not back three cycles after a store");

endmodule : lsu_tb

//--- hw/data_memory.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

module data_memory (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  logic                we_i,
    input  logic [31:0]         addr_i,
    input  logic [3:0]          be_i,
    input  lsu_pkg::data_word_t wdata_i,
    output lsu_pkg::data_word_t rdata_o,
    output logic                rvalid_o,
    output logic                wdone_o
);

    localparam int unsigned DEPTH = `LSU_MEM_WORDS;
    localparam int unsigned LAT   = `LSU_MEM_LATENCY;
    localparam int unsigned AW    = $clog2(DEPTH);

    lsu_pkg::data_word_t mem_q [DEPTH];
    lsu_pkg::data_word_t rd_pipe_q [LAT];
    logic [LAT-1:0]      rd_valid_q;
    logic [AW-1:0]       word_idx;
    logic                rd_req;
    logic                wr_req;
    logic                wdone_q;

    // byte address in, word index for the array
    assign word_idx = addr_i[AW+1:2];
    assign rd_req   = req_i & ~we_i;
    assign wr_req   = req_i & we_i;

    // --------------------------------------------------------------------------
    // storage, byte-enable writes
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (wr_req) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem_q[word_idx].word8[b] <= wdata_i.word8[b];
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // read return pipeline
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rd_req) begin
            rd_pipe_q[0] <= mem_q[word_idx];
        end
        for (int s = 1; s < LAT; s++) begin
            rd_pipe_q[s] <= rd_pipe_q[s-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= '0;
            wdone_q    <= 1'b0;
        end else begin
            rd_valid_q[0] <= rd_req;
            for (int s = 1; s < LAT; s++) begin
                rd_valid_q[s] <= rd_valid_q[s-1];
            end
            wdone_q <= wr_req;
        end
    end

    assign rdata_o  = rd_pipe_q[LAT-1];
    assign rvalid_o = rd_valid_q[LAT-1];
    assign wdone_o  = wdone_q;

endmodule : data_memory

//--- hw/load_unit.sv
`timescale 1ns/1ps

module load_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  lsu_pkg::ldu_uop_t   uop_i,
    input  logic [31:0]         addr_i,
    input  lsu_pkg::data_word_t mem_rdata_i,
    input  logic                mem_rvalid_i,
    input  logic                result_ready_i,
    output logic                mem_req_o,
    output logic [31:0]         mem_addr_o,
    output logic                idle_o,
    output logic                result_valid_o,
    output logic [31:0]         result_data_o
);

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT,
        LD_DATA_VALID
    } ld_state_e;

    ld_state_e           state_q;
    ld_state_e           state_d;
    lsu_pkg::ldu_uop_t   uop_q;
    logic [1:0]          lane_q;
    lsu_pkg::data_word_t data_q;
    logic [7:0]          lane8;
    logic [15:0]         lane16;

    // --------------------------------------------------------------------------
    // operation and data registers
    // --------------------------------------------------------------------------

    // only the low address bits matter once the request is out
    always_ff @(posedge clk_i) begin
        if (start_i && (state_q == LD_IDLE)) begin
            uop_q  <= uop_i;
            lane_q <= addr_i[1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == LD_WAIT) && mem_rvalid_i) begin
            data_q <= mem_rdata_i;
        end
    end

    // word aligned request address
    assign mem_addr_o = {addr_i[31:2], 2'b00};

    // --------------------------------------------------------------------------
    // FSM
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= LD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d        = state_q;
        mem_req_o      = 1'b0;
        idle_o         = 1'b0;
        result_valid_o = 1'b0;

        case (state_q)
            LD_IDLE: begin
                idle_o = 1'b1;
                // request goes out in the start cycle
                if (start_i) begin
                    mem_req_o = 1'b1;
                    state_d   = LD_WAIT;
                end
            end

            LD_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = LD_DATA_VALID;
                end
            end

            LD_DATA_VALID: begin
                // hold until the consumer takes it
                result_valid_o = 1'b1;
                if (result_ready_i) begin
                    state_d = LD_IDLE;
                end
            end

            default: begin
                state_d = LD_IDLE;
            end
        endcase
    end

    // --------------------------------------------------------------------------
    // lane extraction and extension
    // --------------------------------------------------------------------------

    assign lane8  = data_q.word8[lane_q];
    assign lane16 = data_q.word16[lane_q[1]];

    always_comb begin
        case (uop_q.width)
            lsu_pkg::MEM_BYTE: begin
                if (uop_q.signed_load) begin
                    result_data_o = {{24{lane8[7]}}, lane8};
                end else begin
                    result_data_o = {24'b0, lane8};
                end
            end

            lsu_pkg::MEM_HALF: begin
                if (uop_q.signed_load) begin
                    result_data_o = {{16{lane16[15]}}, lane16};
                end else begin
                    result_data_o = {16'b0, lane16};
                end
            end

            default: begin
                result_data_o = data_q.word32;
            end
        endcase
    end

    // memory answers only the request this unit made
    a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rvalid_i |-> (state_q == LD_WAIT));

endmodule : load_unit

//--- hw/lsu_decode.sv
`timescale 1ns/1ps

`include "lsu_params.svh"

module lsu_decode (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                op_valid_i,
    input  logic                is_store_i,
    input  logic [2:0]          funct3_i,
    input  logic [31:0]         base_i,
    input  logic [31:0]         offset_i,
    input  logic [31:0]         store_data_i,
    input  logic                ld_idle_i,
    input  logic                st_idle_i,
    output logic                op_ready_o,
    output logic                ld_start_o,
    output lsu_pkg::ldu_uop_t   ld_uop_o,
    output logic                st_start_o,
    output lsu_pkg::stu_uop_t   st_uop_o,
    output logic [31:0]         ea_o,
    output logic [31:0]         st_data_o
);

    logic                 accept;
    logic                 issue_q;
    logic                 is_store_q;
    logic [31:0]          ea_d;
    lsu_pkg::mem_width_t  width_d;
    lsu_pkg::ldu_uop_t    ld_uop_d;
    lsu_pkg::stu_uop_t    st_uop_d;
    logic [31:0]          ea_q;
    logic [31:0]          st_data_q;
    lsu_pkg::ldu_uop_t    ld_uop_q;
    lsu_pkg::stu_uop_t    st_uop_q;

    // --------------------------------------------------------------------------
    // address generation and width decode
    // --------------------------------------------------------------------------

    assign ea_d = base_i + offset_i;

    always_comb begin
        case (funct3_i[1:0])
            2'd0:    width_d = lsu_pkg::MEM_BYTE;
            2'd1:    width_d = lsu_pkg::MEM_HALF;
            default: width_d = lsu_pkg::MEM_WORD;
        endcase
        // funct3[2] marks the unsigned loads
        ld_uop_d.width       = width_d;
        ld_uop_d.signed_load = ~funct3_i[2];
        st_uop_d.width       = width_d;
    end

    // no new op while one waits for dispatch or a unit still works
    assign op_ready_o = ~issue_q & ld_idle_i & st_idle_i;
    assign accept     = op_valid_i & op_ready_o;

    // --------------------------------------------------------------------------
    // operation register and dispatch
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            is_store_q <= is_store_i;
            ea_q       <= ea_d;
            st_data_q  <= store_data_i;
            ld_uop_q   <= ld_uop_d;
            st_uop_q   <= st_uop_d;
        end
    end

    // one-cycle start pulse to whichever unit owns the op
    assign ld_start_o = issue_q & ~is_store_q;
    assign st_start_o = issue_q & is_store_q;
    assign ld_uop_o   = ld_uop_q;
    assign st_uop_o   = st_uop_q;
    assign ea_o       = ea_q;
    assign st_data_o  = st_data_q;

    // stores have no unsigned variants
    a_funct3_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |-> (funct3_i inside {3'd0, 3'd1, 3'd2}) ||
                   (!is_store_i && (funct3_i inside {3'd4, 3'd5})));

    a_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |-> !((width_d == lsu_pkg::MEM_HALF) && ea_d[0]) &&
                   !((width_d == lsu_pkg::MEM_WORD) && (ea_d[1:0] != 2'b00)));

    a_in_memory: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |-> ea_d < 32'(`LSU_MEM_WORDS * 4));

endmodule : lsu_decode

//--- hw/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// --------------------------------------------------------------------------
// data memory geometry
// --------------------------------------------------------------------------

// depth in 32-bit words
`define LSU_MEM_WORDS 256

// cycles from read request to rvalid, must be 1 or more
`define LSU_MEM_LATENCY 2

`endif

//--- hw/lsu_pkg.sv
package lsu_pkg;

    // --------------------------------------------------------------------------
    // access width, taken from funct3[1:0]
    // --------------------------------------------------------------------------

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_width_t;

    // --------------------------------------------------------------------------
    // one memory word, seen as word, halfwords or bytes
    // --------------------------------------------------------------------------

    typedef union packed {
        logic [31:0]      word32;
        logic [1:0][15:0] word16;
        logic [3:0][7:0]  word8;
    } data_word_t;

    // --------------------------------------------------------------------------
    // micro-operations handed to the units
    // --------------------------------------------------------------------------

    // load: width plus sign extension select
    typedef struct packed {
        mem_width_t width;
        logic       signed_load;
    } ldu_uop_t;

    // store: width only, lanes come from the address
    typedef struct packed {
        mem_width_t width;
    } stu_uop_t;

endpackage : lsu_pkg

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        op_valid_i,
    input  logic        is_store_i,
    input  logic [2:0]  funct3_i,
    input  logic [31:0] base_i,
    input  logic [31:0] offset_i,
    input  logic [31:0] store_data_i,
    output logic        op_ready_o,
    output logic        result_valid_o,
    output logic [31:0] result_data_o,
    input  logic        result_ready_i
);

    logic                ld_start;
    logic                st_start;
    lsu_pkg::ldu_uop_t   ld_uop;
    lsu_pkg::stu_uop_t   st_uop;
    logic [31:0]         ea;
    logic [31:0]         st_data;
    logic                ld_idle;
    logic                st_idle;
    logic                ld_req;
    logic [31:0]         ld_addr;
    logic                st_req;
    logic                st_we;
    logic [31:0]         st_addr;
    logic [3:0]          st_be;
    lsu_pkg::data_word_t st_wdata;
    logic                mem_req;
    logic                mem_we;
    logic [31:0]         mem_addr;
    lsu_pkg::data_word_t mem_rdata;
    logic                mem_rvalid;
    logic                mem_wdone;

    lsu_decode u_decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .op_valid_i   (op_valid_i),
        .is_store_i   (is_store_i),
        .funct3_i     (funct3_i),
        .base_i       (base_i),
        .offset_i     (offset_i),
        .store_data_i (store_data_i),
        .ld_idle_i    (ld_idle),
        .st_idle_i    (st_idle),
        .op_ready_o   (op_ready_o),
        .ld_start_o   (ld_start),
        .ld_uop_o     (ld_uop),
        .st_start_o   (st_start),
        .st_uop_o     (st_uop),
        .ea_o         (ea),
        .st_data_o    (st_data)
    );

    load_unit u_load (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .start_i        (ld_start),
        .uop_i          (ld_uop),
        .addr_i         (ea),
        .mem_rdata_i    (mem_rdata),
        .mem_rvalid_i   (mem_rvalid),
        .result_ready_i (result_ready_i),
        .mem_req_o      (ld_req),
        .mem_addr_o     (ld_addr),
        .idle_o         (ld_idle),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o)
    );

    store_unit u_store (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (st_start),
        .uop_i       (st_uop),
        .addr_i      (ea),
        .data_i      (st_data),
        .mem_wdone_i (mem_wdone),
        .mem_req_o   (st_req),
        .mem_we_o    (st_we),
        .mem_addr_o  (st_addr),
        .mem_be_o    (st_be),
        .mem_wdata_o (st_wdata),
        .idle_o      (st_idle)
    );

    // --------------------------------------------------------------------------
    // memory port sharing, the store side wins when it requests
    // --------------------------------------------------------------------------

    assign mem_req  = ld_req | st_req;
    assign mem_we   = st_req & st_we;
    assign mem_addr = st_req ? st_addr : ld_addr;

    data_memory u_mem (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (mem_req),
        .we_i     (mem_we),
        .addr_i   (mem_addr),
        .be_i     (st_be),
        .wdata_i  (st_wdata),
        .rdata_o  (mem_rdata),
        .rvalid_o (mem_rvalid),
        .wdone_o  (mem_wdone)
    );

    // decode serialises, so the units never overlap
    a_one_unit_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ld_req && st_req) && (ld_idle || st_idle));

endmodule : lsu_top

//--- hw/store_unit.sv
`timescale 1ns/1ps

module store_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  lsu_pkg::stu_uop_t   uop_i,
    input  logic [31:0]         addr_i,
    input  logic [31:0]         data_i,
    input  logic                mem_wdone_i,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output logic [31:0]         mem_addr_o,
    output logic [3:0]          mem_be_o,
    output lsu_pkg::data_word_t mem_wdata_o,
    output logic                idle_o
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } st_state_e;

    st_state_e state_q;
    st_state_e state_d;

    // --------------------------------------------------------------------------
    // lane placement and byte enables
    // --------------------------------------------------------------------------

    // replicate the narrow data on every lane, the enables pick one
    always_comb begin
        mem_wdata_o.word32 = data_i;
        mem_be_o           = 4'b1111;

        case (uop_i.width)
            lsu_pkg::MEM_BYTE: begin
                mem_wdata_o.word8 = {4{data_i[7:0]}};
                mem_be_o          = 4'b0001 << addr_i[1:0];
            end

            lsu_pkg::MEM_HALF: begin
                mem_wdata_o.word16 = {2{data_i[15:0]}};
                mem_be_o           = addr_i[1] ? 4'b1100 : 4'b0011;
            end

            default: begin
                mem_wdata_o.word32 = data_i;
                mem_be_o           = 4'b1111;
            end
        endcase
    end

    assign mem_addr_o = {addr_i[31:2], 2'b00};

    // --------------------------------------------------------------------------
    // write request FSM
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        mem_req_o = 1'b0;
        idle_o    = (state_q == ST_IDLE);

        if (state_q == ST_IDLE) begin
            // write commits on the start edge
            if (start_i) begin
                mem_req_o = 1'b1;
                state_d   = ST_WAIT;
            end
        end else if (mem_wdone_i) begin
            state_d = ST_IDLE;
        end
    end

    assign mem_we_o = mem_req_o;

    a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |-> (mem_be_o != 4'b0000));

    // wdone only answers our own write
    a_wdone_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_wdone_i |-> (state_q == ST_WAIT));

endmodule : store_unit

//--- run_sim.sh
#!/bin/sh
# builds the LSU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module lsu_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vlsu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    exit 0
else
    exit 1
fi

//--- sim.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/load_unit.sv
hw/store_unit.sv
hw/data_memory.sv
hw/lsu_top.sv
bench/lsu_tb.sv
